//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tv_tb
FILELIST  := filelist.f
MDIR      := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)

//--- dv/tv_clk_gen.sv
// Testbench clock and reset generator
`timescale 1ns/1ps

module tv_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic CLK,
  output logic arst_n
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;    // Released away from the active edge
  end

endmodule

//--- dv/tv_tb.sv
// Directed tests for the display processor
// APB access tasks, screen reference model, compare tasks, reporting
`timescale 1ns/1ps
`include "tv_params.svh"

module tv_tb;

  localparam int COLS      = int'(`TV_NUM_COLS);
  localparam int ROWS      = int'(`TV_NUM_ROWS);
  localparam int FRAME     = ROWS * COLS;
  localparam int CHR_B     = int'(`TV_CHR_BASE);
  localparam int BGM_B     = int'(`TV_BGM_BASE);
  localparam int REG_B     = int'(`TV_REG_BASE);
  localparam int EXP_HS    = COLS - int'(`TV_HS_FIRST) + int'(`TV_HS_LAST) + 1;
  localparam int EXP_VS    = ROWS - int'(`TV_VS_FIRST) + int'(`TV_VS_LAST) + 1;
  localparam int APB_TMO   = 16;
  localparam int FRM_TMO   = 3 * FRAME;
  localparam int SETTLE_NS = 10;     // Quarter clock after the falling edge

  logic                  CLK, arst_n;
  logic                  PSEL, PENABLE, PWRITE;
  logic [`TV_ADDR_W-1:0] PADDR;
  logic [7:0]            PWDATA, PRDATA;
  logic                  PREADY, PSLVERR;
  tv_pkg::tv_rgb_t       RGB;
  logic                  DE, HS, VS, VBL;

  integer     seed;
  int         errors, checks, tests, failed;
  int         de_lines, vs_cyc, vbl_cyc, de_vbl;   // Frame statistics
  logic [7:0] chr_m [`TV_CHR_DEPTH];                // Shadow of host writes
  logic [7:0] bgm_m [`TV_BGM_DEPTH];
  logic [7:0] regs_m [`TV_NUM_REGS];

  tv_clk_gen u_clk_gen (.CLK, .arst_n);

  tv_top DUT (
    .CLK, .arst_n, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .PRDATA, .PREADY, .PSLVERR, .RGB, .DE, .HS, .VS, .VBL
  );

  //////////////////////////////
  // Compare tasks

  task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic compare_resp(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_rgb(input string name, input tv_pkg::tv_rgb_t got,
                             input tv_pkg::tv_rgb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got 0x%06h, expected 0x%06h", name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // APB host

  task automatic apb_xfer(input logic wr, input logic [`TV_ADDR_W-1:0] addr,
                          input logic [7:0] wdata, output logic [7:0] rdata,
                          output logic err, output int waits);
    int n;
    bit ready;
    @(negedge CLK);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = wr;
    PADDR   = addr;
    PWDATA  = wdata;
    @(negedge CLK);
    PENABLE = 1'b1;
    n     = 0;
    ready = 1'b0;
    rdata = 8'hxx;
    err   = 1'bx;
    while (!ready && n < APB_TMO) begin
      if (n > 0)
        @(negedge CLK);
      #(SETTLE_NS);         // Sample inside the access cycle
      n++;
      if (PREADY === 1'b1) begin
        ready = 1'b1;
        rdata = PRDATA;
        err   = PSLVERR;
      end
    end
    if (!ready) begin
      errors++;
      $display("timeout: APB access to 0x%04h never got PREADY", addr);
    end
    waits = n - 1;
    @(posedge CLK);         // Transfer ends on this edge
    @(negedge CLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic apb_write(input logic [`TV_ADDR_W-1:0] addr, input logic [7:0] data,
                           output logic err);
    logic [7:0] unused_rd;
    int         unused_w;
    apb_xfer(1'b1, addr, data, unused_rd, err, unused_w);
  endtask

  task automatic apb_read(input logic [`TV_ADDR_W-1:0] addr, output logic [7:0] data,
                          output logic err, output int waits);
    apb_xfer(1'b0, addr, 8'h00, data, err, waits);
  endtask

  // Mapped write, also kept in the shadow copy
  task automatic store_byte(input int a, input logic [7:0] data);
    logic err;
    apb_write(13'(a), data, err);
    compare_resp($sformatf("PSLVERR write 0x%04h", a), err, 1'b0);
    if (a >= CHR_B && a < CHR_B + `TV_CHR_DEPTH)
      chr_m[a - CHR_B] = data;
    else if (a >= BGM_B && a < BGM_B + `TV_BGM_DEPTH)
      bgm_m[a - BGM_B] = data;
    else if (a >= REG_B && a < REG_B + `TV_NUM_REGS)
      regs_m[a - REG_B] = data;
  endtask

  //////////////////////////////
  // Reference model

  function automatic tv_pkg::tv_rgb_t rgb_of(input tv_pkg::tv_color_t c);
    case (c)
      4'd0:  return {8'd0,   8'd0,   8'd155};
      4'd1:  return {8'd0,   8'd0,   8'd0};
      4'd2:  return {8'd0,   8'd0,   8'd255};
      4'd3:  return {8'd161, 8'd0,   8'd255};
      4'd4:  return {8'd0,   8'd255, 8'd0};
      4'd5:  return {8'd160, 8'd255, 8'd157};
      4'd6:  return {8'd0,   8'd255, 8'd255};
      4'd7:  return {8'd0,   8'd161, 8'd0};
      4'd8:  return {8'd255, 8'd0,   8'd0};
      4'd9:  return {8'd255, 8'd161, 8'd0};
      4'd10: return {8'd255, 8'd0,   8'd255};
      4'd11: return {8'd255, 8'd160, 8'd159};
      4'd12: return {8'd255, 8'd255, 8'd0};
      4'd13: return {8'd163, 8'd160, 8'd0};
      4'd14: return {8'd161, 8'd160, 8'd157};
      default: return {8'd255, 8'd255, 8'd255};
    endcase
  endfunction

  // Colour of active pixel (x, y)
  function automatic tv_pkg::tv_color_t model_pixel(input int x, input int y);
    tv_pkg::tv_ctrl_t     c;
    tv_pkg::tv_clr_pair_t bc, cc;
    tv_pkg::tv_split_t    s;
    int         tx, ty, sel;
    logic [7:0] b, pat;
    logic       xw, yw, bitv;
    c  = regs_m[0];
    bc = regs_m[1];
    s  = regs_m[2];
    cc = regs_m[3];
    tx = x / 8;
    ty = y / 8;
    b  = bgm_m[(ty / 2) * 32 + tx];
    xw = ((tx / 2) < int'(s.xmax)) ^ c.bm_invx;
    yw = ((ty / 2) < int'(s.ymax)) ^ c.bm_invy;
    if (xw && yw) begin
      pat  = (ty % 2 == 1) ? 8'h00 : chr_m[int'(b[6:0]) * 8 + y % 8];
      pat  = pat >> (7 - x % 8);        // Leftmost pixel is bit 7
      bitv = pat[0];
      return bitv ? cc.fg : cc.bg;
    end
    if (!c.bm_ena)
      return bc.bg;
    if (c.bm_hires) begin
      sel  = (y / 4) % 4;               // Quarter 0 uses bits 7:6
      b    = b >> (6 - 2 * sel);
      bitv = (x % 8 < 4) ? b[1] : b[0];
      return bitv ? bc.fg : bc.bg;
    end
    return ((y / 8) % 2 == 1) ? b[3:0] : b[7:4];
  endfunction

  //////////////////////////////
  // Frame scan

  task automatic wait_frame_start(output bit ok);
    int n, phase;
    n = 0;
    phase = 0;
    while (phase < 3 && n < FRM_TMO) begin
      @(negedge CLK);
      n++;
      case (phase)
        0: if (VS === 1'b1) phase = 1;
        1: if (VS === 1'b0) phase = 2;
        default: if (DE === 1'b1) phase = 3;   // First active pixel
      endcase
    end
    ok = (phase == 3);
    if (!ok) begin
      errors++;
      $display("timeout: no frame start seen on VS and DE");
    end
  endtask

  // One frame from pixel (0,0), windows of one line each
  task automatic check_frame(input bit check_pix);
    int t, de_cnt, hs_cnt;
    bit ok;
    de_lines = 0;
    vs_cyc   = 0;
    vbl_cyc  = 0;
    de_vbl   = 0;
    de_cnt   = 0;
    hs_cnt   = 0;
    wait_frame_start(ok);
    if (!ok)
      return;
    for (t = 0; t < FRAME; t++) begin
      if (t > 0)
        @(negedge CLK);
      if (DE === 1'b1) begin
        if (check_pix && de_cnt < int'(`TV_ACT_COLS) && de_lines < int'(`TV_ACT_ROWS))
          compare_rgb($sformatf("RGB(%0d,%0d)", de_cnt, de_lines), RGB,
                      rgb_of(model_pixel(de_cnt, de_lines)));
        if (VBL === 1'b1)
          de_vbl++;
        de_cnt++;
      end
      if (HS === 1'b1)
        hs_cnt++;
      if (VS === 1'b1)
        vs_cyc++;
      if (VBL === 1'b1)
        vbl_cyc++;
      if ((t + 1) % COLS == 0) begin
        if (de_cnt != 0) begin
          compare_count($sformatf("DE per line %0d", de_lines), de_cnt, int'(`TV_ACT_COLS));
          de_lines++;
        end
        compare_count("HS per line", hs_cnt, EXP_HS);
        de_cnt = 0;
        hs_cnt = 0;
      end
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: FAILED with %0d errors", name, errors - err_before);
    end
  endtask

  //////////////////////////////
  // Tests

  task automatic test_registers();
    logic [7:0] v [`TV_NUM_REGS];
    logic [7:0] d;
    logic       err;
    int         i, w, e0;
    e0 = errors;
    for (i = 0; i < `TV_NUM_REGS; i++) begin
      v[i] = 8'($random(seed));
      store_byte(REG_B + i, v[i]);
    end
    for (i = 0; i < `TV_NUM_REGS; i++) begin
      apb_read(13'(REG_B + i), d, err, w);
      compare_byte($sformatf("PRDATA reg %0d", i), d, v[i]);
      compare_resp("PSLVERR", err, 1'b0);
      compare_count("read wait states", w, 1);
    end
    report_test("registers", e0);
  endtask

  task automatic test_memory();
    logic [7:0] d;
    logic       err;
    int         i, w, e0;
    e0 = errors;
    for (i = 0; i < `TV_CHR_DEPTH; i++)
      store_byte(CHR_B + i, 8'($random(seed)));
    for (i = 0; i < `TV_BGM_DEPTH; i++)
      store_byte(BGM_B + i, 8'($random(seed)));
    for (i = 0; i < `TV_CHR_DEPTH; i++) begin
      apb_read(13'(CHR_B + i), d, err, w);
      compare_byte($sformatf("PRDATA chr[%0d]", i), d, chr_m[i]);
    end
    for (i = 0; i < `TV_BGM_DEPTH; i++) begin
      apb_read(13'(BGM_B + i), d, err, w);
      compare_byte($sformatf("PRDATA bgm[%0d]", i), d, bgm_m[i]);
    end
    // Just past the register block, low bits alias reg 0 and chr[4]
    apb_write(13'h1404, 8'h5a, err);
    compare_resp("PSLVERR unmapped write", err, 1'b1);
    apb_read(13'h1404, d, err, w);
    compare_resp("PSLVERR unmapped read", err, 1'b1);
    compare_byte("PRDATA unmapped", d, 8'h00);
    apb_read(13'(REG_B), d, err, w);
    compare_byte("PRDATA reg 0 after unmapped write", d, regs_m[0]);
    apb_read(13'(CHR_B + 4), d, err, w);
    compare_byte("PRDATA chr[4] after unmapped write", d, chr_m[4]);
    report_test("memory and errors", e0);
  endtask

  task automatic test_char_screen();
    logic [6:0] code;
    int         i, e0;
    e0 = errors;
    code = 7'($random(seed));
    for (i = 0; i < 8; i++)
      store_byte(CHR_B + int'(code) * 8 + i, 8'($random(seed)));
    for (i = 0; i < `TV_BGM_DEPTH; i++)
      store_byte(BGM_B + i, {1'b0, code});
    store_byte(REG_B + 0, 8'h00);              // Bitmap off, no inversion
    store_byte(REG_B + 1, 8'($random(seed)));
    store_byte(REG_B + 2, 8'hff);              // Whole screen in the window
    store_byte(REG_B + 3, 8'($random(seed)));
    check_frame(1'b1);
    report_test("character screen", e0);
  endtask

  task automatic test_bitmap_screen();
    tv_pkg::tv_ctrl_t c;
    int               i, e0;
    e0 = errors;
    for (i = 0; i < `TV_BGM_DEPTH; i++)
      store_byte(BGM_B + i, 8'($random(seed)));
    c = '0;
    c.bm_ena = 1'b1;
    store_byte(REG_B + 0, c);
    store_byte(REG_B + 1, 8'($random(seed)));
    store_byte(REG_B + 2, 8'h00);
    check_frame(1'b1);
    c.bm_hires = 1'b1;
    store_byte(REG_B + 0, c);
    check_frame(1'b1);
    report_test("bitmap screen", e0);
  endtask

  task automatic test_window_inversion();
    tv_pkg::tv_ctrl_t  c;
    tv_pkg::tv_split_t s;
    int                e0;
    e0 = errors;
    s.ymax = 4'd4;
    s.xmax = 4'd6;
    c = '0;
    c.bm_ena  = 1'b1;
    c.bm_invx = 1'b1;
    c.bm_invy = 1'b1;
    store_byte(REG_B + 2, s);
    store_byte(REG_B + 0, c);
    check_frame(1'b1);     // Characters only in the lower right corner
    report_test("window inversion", e0);
  endtask

  task automatic test_sync_shape();
    int e0;
    e0 = errors;
    check_frame(1'b0);
    compare_count("DE lines per frame", de_lines, int'(`TV_ACT_ROWS));
    compare_count("VS cycles per frame", vs_cyc, EXP_VS * COLS);
    compare_count("VBL cycles per frame", vbl_cyc, (ROWS - int'(`TV_ACT_ROWS)) * COLS);
    compare_count("DE cycles with VBL high", de_vbl, 0);
    report_test("sync shape", e0);
  endtask

  //////////////////////////////
  // Main sequence

  initial begin
    int n;
    seed    = 13;
    errors  = 0;
    checks  = 0;
    tests   = 0;
    failed  = 0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = 8'h00;
    n = 0;
    while (arst_n !== 1'b1 && n < 10) begin
      @(negedge CLK);
      n++;
    end
    if (arst_n !== 1'b1) begin
      errors++;
      $display("timeout: reset was never released");
    end
    compare_resp("PREADY after reset", PREADY, 1'b0);
    compare_resp("PSLVERR after reset", PSLVERR, 1'b0);
    test_registers();
    test_memory();
    test_char_screen();
    test_bitmap_screen();
    test_window_inversion();
    test_sync_shape();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
hw/tv_pkg.sv
hw/tv_ifs.sv
hw/tv_bus_decode.sv
hw/tv_raster.sv
hw/tv_bg_render.sv
hw/tv_video_out.sv
hw/tv_top.sv
dv/tv_clk_gen.sv
dv/tv_tb.sv

//--- hw/tv_bg_render.sv
// BGM and CHR dual-port memories
// Two-stage background pipeline: BGM fetch, then CHR fetch and colour
`timescale 1ns/1ps
`include "tv_params.svh"

module tv_bg_render (
  input  logic              CLK,
  input  logic [8:0]        row,
  input  logic [8:0]        col,
  input  logic              in_act,
  tv_cfg_if.reg_dst         cfg,
  tv_host_mem_if.mem        mem,
  output tv_pkg::tv_color_t pix_clr
);

  logic [7:0] bgm [`TV_BGM_DEPTH];
  logic [7:0] chr [`TV_CHR_DEPTH];

  logic [8:0] px, py;
  logic [4:0] tx, ty;
  logic       xwin, ywin;
  logic [8:0] bgm_ra;
  logic [9:0] chr_ra;
  logic [7:0] bgm_host_q, chr_host_q;
  logic       host_sel_q;

  // Stage one
  tv_pkg::tv_bgm_word_u bgm_q;
  logic       s1_ch, s1_ty0, s1_act;
  logic [3:0] s1_py;
  logic [2:0] s1_pxl;
  logic [1:0] bm_pair;
  logic       bm_bit;
  tv_pkg::tv_color_t bm_clr_c;

  // Stage two
  logic [7:0] chr_q, ch_pat;
  logic       s2_ch, s2_ty0, s2_act, ch_bit;
  logic [2:0] s2_pxl;
  tv_pkg::tv_color_t s2_bm_clr;

  ////////////////////////////////
  // Tile position and window split

  assign px = col - `TV_FIRST_COL;
  assign py = row - `TV_FIRST_ROW;
  assign tx = px[7:3];
  assign ty = py[7:3];
  assign xwin = (tx[4:1] < cfg.split.xmax) ^ cfg.ctrl.bm_invx;
  assign ywin = (ty[4:1] < cfg.split.ymax) ^ cfg.ctrl.bm_invy;
  assign bgm_ra = {ty[4:1], tx};   // Tile pairs share a BGM row

  ////////////////////////////////
  // Memories, host port and render port

  always_ff @(posedge CLK) begin
    if (mem.wr_en && !mem.sel_chr)
      bgm[mem.addr[8:0]] <= mem.wdata;
    if (mem.rd_en && !mem.sel_chr)
      bgm_host_q <= bgm[mem.addr[8:0]];
    bgm_q <= bgm[bgm_ra];
  end

  always_ff @(posedge CLK) begin
    if (mem.wr_en && mem.sel_chr)
      chr[mem.addr] <= mem.wdata;
    if (mem.rd_en && mem.sel_chr)
      chr_host_q <= chr[mem.addr];
    chr_q <= chr[chr_ra];
  end

  always_ff @(posedge CLK) begin
    if (mem.rd_en)
      host_sel_q <= mem.sel_chr;
  end

  assign mem.rdata = host_sel_q ? chr_host_q : bgm_host_q;

  ////////////////////////////////
  // Pipeline

  always_ff @(posedge CLK) begin
    s1_ch     <= xwin & ywin;
    s1_ty0    <= ty[0];
    s1_act    <= in_act;
    s1_py     <= py[3:0];
    s1_pxl    <= px[2:0];
    s2_ch     <= s1_ch;
    s2_ty0    <= s1_ty0;
    s2_act    <= s1_act;
    s2_pxl    <= s1_pxl;
    s2_bm_clr <= bm_clr_c;
  end

  assign chr_ra = {bgm_q.chr.code, s1_py[2:0]};

  // Bitmap colour straight from the BGM byte
  always_comb begin
    bm_pair = bgm_q.hires[~s1_py[3:2]];
    bm_bit  = s1_pxl[2] ? bm_pair[0] : bm_pair[1];
    if (!cfg.ctrl.bm_ena)
      bm_clr_c = cfg.bm_clr.bg;
    else if (cfg.ctrl.bm_hires)
      bm_clr_c = bm_bit ? cfg.bm_clr.fg : cfg.bm_clr.bg;
    else
      bm_clr_c = s1_py[3] ? bgm_q.lores.lo : bgm_q.lores.hi;
  end

  assign ch_pat = s2_ty0 ? 8'h00 : chr_q;    // Odd tile rows are blank
  assign ch_bit = ch_pat[3'd7 - s2_pxl];     // MSB is leftmost

  always_comb begin
    if (!s2_act)
      pix_clr = `TV_BLANK_CLR;
    else if (s2_ch)
      pix_clr = ch_bit ? cfg.ch_clr.fg : cfg.ch_clr.bg;
    else
      pix_clr = s2_bm_clr;
  end

endmodule

//--- hw/tv_bus_decode.sv
// APB slave with region decode
// Control register file and read-back mux
`timescale 1ns/1ps
`include "tv_params.svh"

module tv_bus_decode (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [`TV_ADDR_W-1:0] paddr,
  input  logic [7:0]            pwdata,
  output logic [7:0]            prdata,
  output logic                  pready,
  output logic                  pslverr,
  tv_cfg_if.reg_src             cfg,
  tv_host_mem_if.host           mem
);

  tv_pkg::tv_ctrl_t     ctrl_q;
  tv_pkg::tv_clr_pair_t bm_clr_q;
  tv_pkg::tv_split_t    split_q;
  tv_pkg::tv_clr_pair_t ch_clr_q;

  logic       hit_chr, hit_bgm, hit_reg, hit_mem, hit_none;
  logic       access;
  logic       rd_wait;    // Second access cycle of a read
  logic [7:0] reg_rdata;

  function automatic logic in_rgn(input logic [`TV_ADDR_W-1:0] a,
                                  input logic [`TV_ADDR_W-1:0] base,
                                  input int size);
    logic [`TV_ADDR_W-1:0] off;
    off = a - base;
    return int'(off) < size;
  endfunction

  ////////////////////////////////
  // Address decode

  assign hit_chr  = in_rgn(paddr, `TV_CHR_BASE, `TV_CHR_DEPTH);
  assign hit_bgm  = in_rgn(paddr, `TV_BGM_BASE, `TV_BGM_DEPTH);
  assign hit_reg  = in_rgn(paddr, `TV_REG_BASE, `TV_NUM_REGS);
  assign hit_mem  = hit_chr | hit_bgm;
  assign hit_none = ~(hit_mem | hit_reg);

  ////////////////////////////////
  // Handshake, writes take no wait state

  assign access = psel & penable;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rd_wait <= 1'b0;
    end else begin
      rd_wait <= access & ~pwrite & ~rd_wait;
    end
  end

  assign pready  = access & (pwrite | rd_wait);
  assign pslverr = pready & hit_none;

  // Memory request goes out in the first read cycle
  assign mem.wr_en   = access & pwrite & hit_mem;
  assign mem.rd_en   = access & ~pwrite & ~rd_wait & hit_mem;
  assign mem.sel_chr = hit_chr;
  assign mem.addr    = paddr[`TV_HOST_AW-1:0];
  assign mem.wdata   = pwdata;

  ////////////////////////////////
  // Register file

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q   <= '0;
      bm_clr_q <= '0;
      split_q  <= '0;
      ch_clr_q <= '0;
    end else if (access && pwrite && hit_reg) begin
      case (paddr[1:0])
        2'd0: ctrl_q   <= pwdata;
        2'd1: bm_clr_q <= pwdata;
        2'd2: split_q  <= pwdata;
        2'd3: ch_clr_q <= pwdata;
      endcase
    end
  end

  always_comb begin
    case (paddr[1:0])
      2'd0: reg_rdata = ctrl_q;
      2'd1: reg_rdata = bm_clr_q;
      2'd2: reg_rdata = split_q;
      2'd3: reg_rdata = ch_clr_q;
    endcase
  end

  always_comb begin
    prdata = 8'h00;         // Also for unmapped reads
    if (pready && !pwrite) begin
      if (hit_reg)
        prdata = reg_rdata;
      else if (hit_mem)
        prdata = mem.rdata;
    end
  end

  assign cfg.ctrl   = ctrl_q;
  assign cfg.bm_clr = bm_clr_q;
  assign cfg.split  = split_q;
  assign cfg.ch_clr = ch_clr_q;

  // APB protocol checks on the host side
  a_penable_psel: assert property (@(posedge CLK) disable iff (!arst_n)
    penable |-> psel);
  a_paddr_stable: assert property (@(posedge CLK) disable iff (!arst_n)
    (psel && !(penable && pready)) |=> $stable(paddr));

endmodule

//--- hw/tv_ifs.sv
// tv_cfg_if: control register state from decoder to renderer
// tv_host_mem_if: host access port of the BGM and CHR
`timescale 1ns/1ps
`include "tv_params.svh"

interface tv_cfg_if;
  tv_pkg::tv_ctrl_t     ctrl;
  tv_pkg::tv_clr_pair_t bm_clr;
  tv_pkg::tv_split_t    split;
  tv_pkg::tv_clr_pair_t ch_clr;

  // Static settings, no handshake
  modport reg_src (output ctrl, bm_clr, split, ch_clr);
  modport reg_dst (input ctrl, bm_clr, split, ch_clr);
endinterface

interface tv_host_mem_if;
  logic                   wr_en;
  logic                   rd_en;
  logic                   sel_chr;   // 0 = BGM
  logic [`TV_HOST_AW-1:0] addr;
  logic [7:0]             wdata;
  logic [7:0]             rdata;     // Valid one cycle after rd_en

  modport host (
    output wr_en, rd_en, sel_chr, addr, wdata,
    input  rdata
  );
  modport mem (
    input  wr_en, rd_en, sel_chr, addr, wdata,
    output rdata
  );
endinterface

//--- hw/tv_pkg.sv
// Control register layouts
// BGM byte union (character code or bitmap data)
// Palette index and RGB entry types
package tv_pkg;

  // Register 0
  typedef struct packed {
    logic       bm_invy;    // Invert ymax test
    logic       bm_invx;    // Invert xmax test
    logic       sp_2clr;    // Sprite bits, no sprite engine here
    logic       sp_ena;
    logic [1:0] rsvd;
    logic       bm_hires;   // 1 = hi-res bitmap
    logic       bm_ena;
  } tv_ctrl_t;

  // Registers 1 and 3
  typedef struct packed {
    logic [3:0] fg;
    logic [3:0] bg;
  } tv_clr_pair_t;

  // Register 2, character window size in tile pairs
  typedef struct packed {
    logic [3:0] ymax;
    logic [3:0] xmax;
  } tv_split_t;

  // One BGM byte, decoded per tile type
  typedef union packed {
    struct packed {
      logic       unused;
      logic [6:0] code;
    } chr;
    struct packed {
      logic [3:0] hi;
      logic [3:0] lo;
    } lores;
    logic [3:0][1:0] hires;   // Pair 3 is the top quarter of the tile
  } tv_bgm_word_u;

  typedef logic [3:0] tv_color_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } tv_rgb_t;

endpackage

//--- hw/tv_raster.sv
// Frame row and column counters
// Active, sync and blanking flags decoded from the counters
`timescale 1ns/1ps
`include "tv_params.svh"

module tv_raster (
  input  logic       CLK,
  input  logic       arst_n,
  output logic [8:0] row,
  output logic [8:0] col,
  output logic       in_act,
  output logic       hs_pre,
  output logic       vs_pre,
  output logic       vbl_pre
);

  logic act_row, act_col;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      row <= '0;
      col <= '0;
    end else if (col == `TV_NUM_COLS - 9'd1) begin
      col <= '0;
      row <= (row == `TV_NUM_ROWS - 9'd1) ? 9'd0 : row + 9'd1;
    end else begin
      col <= col + 9'd1;
    end
  end

  assign act_row = (row >= `TV_FIRST_ROW) && (row < `TV_FIRST_ROW + `TV_ACT_ROWS);
  assign act_col = (col >= `TV_FIRST_COL) && (col < `TV_FIRST_COL + `TV_ACT_COLS);

  assign in_act  = act_row & act_col;
  assign hs_pre  = (col >= `TV_HS_FIRST) || (col <= `TV_HS_LAST);  // Wraps through 0
  assign vs_pre  = (row >= `TV_VS_FIRST) || (row <= `TV_VS_LAST);
  assign vbl_pre = ~act_row;

  a_col_range: assert property (@(posedge CLK) disable iff (!arst_n)
    col < `TV_NUM_COLS);

endmodule

//--- hw/tv_top.sv
// Display processor top level
// APB host port, video outputs, submodule wiring
`timescale 1ns/1ps
`include "tv_params.svh"

module tv_top (
  input  logic                  CLK,
  input  logic                  arst_n,
  // APB
  input  logic                  PSEL,
  input  logic                  PENABLE,
  input  logic                  PWRITE,
  input  logic [`TV_ADDR_W-1:0] PADDR,
  input  logic [7:0]            PWDATA,
  output logic [7:0]            PRDATA,
  output logic                  PREADY,
  output logic                  PSLVERR,
  // Video
  output logic [23:0]           RGB,    // {R,G,B}
  output logic                  DE,
  output logic                  HS,
  output logic                  VS,
  output logic                  VBL
);

  logic [8:0] row, col;
  logic       in_act, hs_pre, vs_pre, vbl_pre;
  tv_pkg::tv_color_t pix_clr;

  tv_cfg_if      cfg_if ();
  tv_host_mem_if mem_if ();

  tv_bus_decode u_bus_decode (
    .CLK, .arst_n,
    .psel(PSEL), .penable(PENABLE), .pwrite(PWRITE), .paddr(PADDR), .pwdata(PWDATA),
    .prdata(PRDATA), .pready(PREADY), .pslverr(PSLVERR),
    .cfg(cfg_if.reg_src), .mem(mem_if.host)
  );

  tv_raster u_raster (
    .CLK, .arst_n, .row, .col, .in_act, .hs_pre, .vs_pre, .vbl_pre
  );

  tv_bg_render u_bg_render (
    .CLK, .row, .col, .in_act,
    .cfg(cfg_if.reg_dst), .mem(mem_if.mem), .pix_clr
  );

  tv_video_out u_video_out (
    .CLK, .arst_n, .pix_clr, .in_act, .hs_pre, .vs_pre, .vbl_pre,
    .rgb(RGB), .de(DE), .hs(HS), .vs(VS), .vbl(VBL)
  );

endmodule

//--- hw/tv_video_out.sv
// Fixed 16-entry palette and output registers
// Sync flag delay matched to the render pipeline
`timescale 1ns/1ps

module tv_video_out (
  input  logic              CLK,
  input  logic              arst_n,
  input  tv_pkg::tv_color_t pix_clr,
  input  logic              in_act,
  input  logic              hs_pre,
  input  logic              vs_pre,
  input  logic              vbl_pre,
  output tv_pkg::tv_rgb_t   rgb,
  output logic              de,
  output logic              hs,
  output logic              vs,
  output logic              vbl
);

  tv_pkg::tv_rgb_t pal_rgb;
  logic [3:0]      flg_d1, flg_d2;   // {act, hs, vs, vbl}

  always_comb begin
    case (pix_clr)
      4'd0:  pal_rgb = {8'd0,   8'd0,   8'd155};
      4'd1:  pal_rgb = {8'd0,   8'd0,   8'd0};
      4'd2:  pal_rgb = {8'd0,   8'd0,   8'd255};
      4'd3:  pal_rgb = {8'd161, 8'd0,   8'd255};
      4'd4:  pal_rgb = {8'd0,   8'd255, 8'd0};
      4'd5:  pal_rgb = {8'd160, 8'd255, 8'd157};
      4'd6:  pal_rgb = {8'd0,   8'd255, 8'd255};
      4'd7:  pal_rgb = {8'd0,   8'd161, 8'd0};
      4'd8:  pal_rgb = {8'd255, 8'd0,   8'd0};
      4'd9:  pal_rgb = {8'd255, 8'd161, 8'd0};
      4'd10: pal_rgb = {8'd255, 8'd0,   8'd255};
      4'd11: pal_rgb = {8'd255, 8'd160, 8'd159};
      4'd12: pal_rgb = {8'd255, 8'd255, 8'd0};
      4'd13: pal_rgb = {8'd163, 8'd160, 8'd0};
      4'd14: pal_rgb = {8'd161, 8'd160, 8'd157};
      4'd15: pal_rgb = {8'd255, 8'd255, 8'd255};
    endcase
  end

  always_ff @(posedge CLK) begin
    rgb <= pal_rgb;
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      flg_d1 <= '0;
      flg_d2 <= '0;
      {de, hs, vs, vbl} <= '0;
    end else begin
      flg_d1 <= {in_act, hs_pre, vs_pre, vbl_pre};
      flg_d2 <= flg_d1;
      {de, hs, vs, vbl} <= flg_d2;   // Lines up with rgb
    end
  end

endmodule

//--- include/tv_params.svh
// Raster geometry, sync bands and active window
// APB address map and memory sizes
`ifndef TV_PARAMS_SVH
`define TV_PARAMS_SVH

// Frame size in pixel clocks
`define TV_NUM_ROWS   9'd262
`define TV_NUM_COLS   9'd260

// Active rectangle
`define TV_FIRST_ROW  9'd24
`define TV_ACT_ROWS   9'd222
`define TV_FIRST_COL  9'd24
`define TV_ACT_COLS   9'd192

// Sync bands wrap through zero
`define TV_HS_FIRST   9'd256
`define TV_HS_LAST    9'd15
`define TV_VS_FIRST   9'd256
`define TV_VS_LAST    9'd2

// Host address map
`define TV_ADDR_W     13
`define TV_CHR_BASE   13'h0000
`define TV_BGM_BASE   13'h1000
`define TV_REG_BASE   13'h1400
`define TV_NUM_REGS   4
`define TV_HOST_AW    10          // Widest memory offset (CHR)

`define TV_CHR_DEPTH  1024
`define TV_BGM_DEPTH  512
`define TV_BLANK_CLR  4'd1        // Black

`endif
